//--- Makefile
# Verilator build and run for the DBI loopback path

VERILATOR ?= verilator
TOP       ?= tb_aib_dbi_path
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
hw/aib_dbi_pkg.sv
hw/aib_tx_dbi.sv
hw/aib_rx_dbi.sv
hw/aib_dbi_path.sv
verif/tb_aib_dbi_path.sv

//--- hw/aib_dbi_path.sv
//////////////////////////////////////////////////
// Loopback top. Encoder feeds decoder directly and
// the pin word is brought out for observation.
// Latency is 2 cycles with DBI on, 1 with it off.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module aib_dbi_path (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dbi_en,    // Shared by both stages
  input  aib_dbi_pkg::word_t     data_in,   // Word accepted every clock
  output aib_dbi_pkg::pin_word_s pin_data,  // Pin word between the stages
  output aib_dbi_pkg::word_t     data_out   // Restored word
);

  // Stage 1, encode onto the pins
  aib_tx_dbi u_tx_dbi (
    .clk      (clk),
    .rst_n    (rst_n),
    .dbi_en   (dbi_en),
    .data_in  (data_in),
    .pin_data (pin_data)   // Also drives the observation port
  );

  // Stage 2, decode from the pins
  aib_rx_dbi u_rx_dbi (
    .clk      (clk),
    .rst_n    (rst_n),
    .dbi_en   (dbi_en),
    .pin_data (pin_data),
    .data_out (data_out)
  );

endmodule

//--- hw/aib_dbi_pkg.sv
//////////////////////////////////////////////////
// Shared widths, thresholds and types for the DBI
// transmit/receive path of the 80-bit DDR channel.
// Modules import it inside their bodies.
//////////////////////////////////////////////////

package aib_dbi_pkg;

  // Channel word geometry
  localparam int WORD_W      = 80;              // One word per clock, both edges
  localparam int GRP_W       = 19;              // Data bits per DBI group
  localparam int GRP_THRESH  = 9;               // Invert when toggles exceed this
  localparam int NUM_GRP     = 4;               // Groups, one flag pin each
  localparam int FLAG_PAIR_W = NUM_GRP / 2;     // Flag pins per half word
  localparam int HALF_W      = 2 * GRP_W;       // Data pins per half word

  // First lane index of the high groups; lane 19 holds the low flag pair
  localparam int HI_LANE     = GRP_W + 1;

  // Enough bits to count every toggle in a group
  localparam int CNT_W       = $clog2(GRP_W + 1);

  // One channel word, user side or pin side
  typedef logic [WORD_W-1:0] word_t;

  // One group of even or odd lane bits, lane order
  typedef logic [GRP_W-1:0] grp_t;

  // Group flags
  //   [0] even-low, [1] odd-low
  //   [2] even-high, [3] odd-high
  typedef logic [NUM_GRP-1:0] flags_t;

  // Encoded pin word, pin 79 at the top
  // In each flag pair the odd group sits in the upper bit
  // Data fields keep the DDR order: even pin at 2*j, odd pin at 2*j+1
  typedef struct packed {
    logic [FLAG_PAIR_W-1:0] hi_flags;   // Pins 79 and 78
    logic [HALF_W-1:0]      hi_data;    // Pins 77 down to 40
    logic [FLAG_PAIR_W-1:0] lo_flags;   // Pins 39 and 38
    logic [HALF_W-1:0]      lo_data;    // Pins 37 down to 0
  } pin_word_s;

endpackage

//--- hw/aib_rx_dbi.sv
//////////////////////////////////////////////////
// Receive DBI decoder. Flips flagged groups back
// and clears the flag pins; one register stage.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module aib_rx_dbi (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dbi_en,    // Same level as the transmit side
  input  aib_dbi_pkg::pin_word_s pin_data,  // Word seen on the pins
  output aib_dbi_pkg::word_t     data_out   // Restored user word
);

  import aib_dbi_pkg::*;

  flags_t flags;          // Received flag pins, group order
  grp_t   even_lo;        // Lanes as received
  grp_t   odd_lo;
  grp_t   even_hi;
  grp_t   odd_hi;
  grp_t   dec_even_lo;    // Lanes after undoing inversion
  grp_t   dec_odd_lo;
  grp_t   dec_even_hi;
  grp_t   dec_odd_hi;
  word_t  dec_word;       // Decoded word, flags cleared
  word_t  next_out;

  assign flags = {pin_data.hi_flags, pin_data.lo_flags};

  // Pull the four lanes out of the pin halves
  always_comb
  begin
    for (int j = 0; j < GRP_W; j++)
    begin
      even_lo[j] = pin_data.lo_data[2*j];
      odd_lo[j]  = pin_data.lo_data[2*j+1];
      even_hi[j] = pin_data.hi_data[2*j];
      odd_hi[j]  = pin_data.hi_data[2*j+1];
    end
  end

  assign dec_even_lo = even_lo ^ {GRP_W{flags[0]}};
  assign dec_odd_lo  = odd_lo  ^ {GRP_W{flags[1]}};
  assign dec_even_hi = even_hi ^ {GRP_W{flags[2]}};
  assign dec_odd_hi  = odd_hi  ^ {GRP_W{flags[3]}};

  // Put the lanes back in place; flag pins read as zero
  always_comb
  begin
    dec_word = '0;
    for (int j = 0; j < GRP_W; j++)
    begin
      dec_word[2*j]            = dec_even_lo[j];
      dec_word[2*j+1]          = dec_odd_lo[j];
      dec_word[2*(HI_LANE+j)]   = dec_even_hi[j];
      dec_word[2*(HI_LANE+j)+1] = dec_odd_hi[j];
    end
  end

  // Raw pins when DBI is off
  assign next_out = dbi_en ? dec_word : word_t'(pin_data);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      data_out <= '0;
    else
      data_out <= next_out;
  end

  // Transmit stage and channel must never hand over X or Z
  a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(data_out))
    else $error("Unknown bits on decoded data_out");

endmodule

//--- hw/aib_tx_dbi.sv
//////////////////////////////////////////////////
// Transmit DBI encoder. Counts lane toggles per
// group, inverts busy groups and registers the
// pin word. With DBI off the input goes straight out.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module aib_tx_dbi (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dbi_en,    // Quasi-static, changed while idle
  input  aib_dbi_pkg::word_t     data_in,   // User word, even bits on first edge
  output aib_dbi_pkg::pin_word_s pin_data   // Encoded or raw pin word
);

  import aib_dbi_pkg::*;

  grp_t      even_lo;       // Raw even lane, low group
  grp_t      odd_lo;        // Raw odd lane, low group
  grp_t      even_hi;
  grp_t      odd_hi;
  logic [1:0] even_flag;    // [0] low group, [1] high group
  logic [1:0] odd_flag;
  grp_t      enc_even_lo;   // Even lanes after inversion
  grp_t      enc_even_hi;
  grp_t      enc_odd_lo;
  grp_t      enc_odd_hi;
  flags_t    flags;
  pin_word_s enc_word;      // Next encoded word
  pin_word_s enc_q;         // Encoded word on the pins last cycle

  // Gather one group of even lane bits, starting at lane base
  function automatic grp_t even_grp(word_t w, int base);
    grp_t g;
    for (int k = 0; k < GRP_W; k++)
      g[k] = w[2*(base+k)];
    return g;
  endfunction

  function automatic grp_t odd_grp(word_t w, int base);
    grp_t g;
    for (int k = 0; k < GRP_W; k++)
      g[k] = w[2*(base+k)+1];
    return g;
  endfunction

  // True when more than GRP_THRESH bits differ
  function automatic logic over_thresh(grp_t cur_grp, grp_t cmp_grp);
    logic [CNT_W-1:0] cnt;
    cnt = '0;
    for (int k = 0; k < GRP_W; k++)
      cnt = cnt + CNT_W'(cur_grp[k] ^ cmp_grp[k]);
    return cnt > CNT_W'(GRP_THRESH);
  endfunction

  // Split the user word into its DDR lanes
  assign even_lo = even_grp(data_in, 0);
  assign odd_lo  = odd_grp(data_in, 0);
  assign even_hi = even_grp(data_in, HI_LANE);
  assign odd_hi  = odd_grp(data_in, HI_LANE);

  // Even bits follow the odd bits of the previous pin word in time
  assign even_flag[0] = over_thresh(even_lo, odd_grp(word_t'(enc_q), 0));
  assign even_flag[1] = over_thresh(even_hi, odd_grp(word_t'(enc_q), HI_LANE));

  assign enc_even_lo = even_lo ^ {GRP_W{even_flag[0]}};
  assign enc_even_hi = even_hi ^ {GRP_W{even_flag[1]}};

  // Odd bits follow the encoded even bits of the same word
  assign odd_flag[0] = over_thresh(odd_lo, enc_even_lo);
  assign odd_flag[1] = over_thresh(odd_hi, enc_even_hi);

  assign enc_odd_lo = odd_lo ^ {GRP_W{odd_flag[0]}};
  assign enc_odd_hi = odd_hi ^ {GRP_W{odd_flag[1]}};

  assign flags = {odd_flag[1], even_flag[1], odd_flag[0], even_flag[0]};

  // Interleave the lanes back onto the pins
  always_comb
  begin
    enc_word.hi_flags = flags[3:2];   // Pins 79, 78
    enc_word.lo_flags = flags[1:0];   // Pins 39, 38
    for (int j = 0; j < GRP_W; j++)
    begin
      enc_word.lo_data[2*j]   = enc_even_lo[j];
      enc_word.lo_data[2*j+1] = enc_odd_lo[j];
      enc_word.hi_data[2*j]   = enc_even_hi[j];
      enc_word.hi_data[2*j+1] = enc_odd_hi[j];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      enc_q <= '0;
    else
      enc_q <= enc_word;
  end

  // Bypass is combinational, zero cycles
  assign pin_data = dbi_en ? enc_q : pin_word_s'(data_in);

  // Each registered group stays within the toggle limit against the
  // odd lane one word earlier or the even lane of the same word
  a_toggle_limit: assert property (@(posedge clk) disable iff (!rst_n)
    dbi_en |->
      !over_thresh(even_grp(enc_q, 0), odd_grp($past(enc_q), 0)) &&
      !over_thresh(even_grp(enc_q, HI_LANE), odd_grp($past(enc_q), HI_LANE)) &&
      !over_thresh(odd_grp(enc_q, 0), even_grp(enc_q, 0)) &&
      !over_thresh(odd_grp(enc_q, HI_LANE), even_grp(enc_q, HI_LANE)))
    else $error("DBI group exceeds toggle limit on pins");

endmodule

//--- verif/aib_dbi_tests.txt
# Columns: mode (0 bypass, 1 DBI), input word, expected data_out word; words in 80-bit hex
# With DBI on, pins 38, 39, 78 and 79 carry flags and come back as zero
# Bypass warm-up, flag pins pass raw
0 00000000000000000000 00000000000000000000
0 0123456789ABCDEF0123 0123456789ABCDEF0123
0 FFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFF
0 5555555555AAAAAAAAAA 5555555555AAAAAAAAAA
0 C000000000C000000000 C000000000C000000000
0 DEADBEEFCAFEF00D1234 DEADBEEFCAFEF00D1234
# DBI worst cases, toggling patterns after all zeros
1 00000000000000000000 00000000000000000000
1 FFFFFFFFFFFFFFFFFFFF 3FFFFFFFFF3FFFFFFFFF
1 00000000000000000000 00000000000000000000
1 55555555555555555555 15555555551555555555
1 AAAAAAAAAAAAAAAAAAAA 2AAAAAAAAA2AAAAAAAAA
1 55555555555555555555 15555555551555555555
1 0000000000FFFFFFFFFF 00000000003FFFFFFFFF
1 FFFFFFFFFF0000000000 3FFFFFFFFF0000000000
1 C000000000C000000000 00000000000000000000
1 33333333333333333333 33333333333333333333
1 CCCCCCCCCCCCCCCCCCCC 0CCCCCCCCC0CCCCCCCCC
1 0F0F0F0F0F0F0F0F0F0F 0F0F0F0F0F0F0F0F0F0F
1 F0F0F0F0F0F0F0F0F0F0 30F0F0F0F030F0F0F0F0
1 0123456789ABCDEF0123 01234567892BCDEF0123
1 DEADBEEFCAFEF00D1234 1EADBEEFCA3EF00D1234
1 80000000018000000001 00000000010000000001
1 FEDCBA9876543210FEDC 3EDCBA9876143210FEDC
1 AAAAAAAAAA5555555555 2AAAAAAAAA1555555555
1 5555555555AAAAAAAAAA 15555555552AAAAAAAAA
1 FFFFFFFFFFFFFFFFFFFF 3FFFFFFFFF3FFFFFFFFF
1 FFFFFFFFFFFFFFFFFFFF 3FFFFFFFFF3FFFFFFFFF
1 00000000000000000000 00000000000000000000
# Back to bypass
0 123456789ABCDEF01234 123456789ABCDEF01234
0 FFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFF
0 00000000000000000000 00000000000000000000
0 A5A5A5A5A5A5A5A5A5A5 A5A5A5A5A5A5A5A5A5A5
# DBI again
1 00000000000000000000 00000000000000000000
1 55555555555555555555 15555555551555555555
1 00000000000000000000 00000000000000000000
1 AAAAAAAAAAAAAAAAAAAA 2AAAAAAAAA2AAAAAAAAA
1 A5A5A5A5A5A5A5A5A5A5 25A5A5A5A525A5A5A5A5
1 5A5A5A5A5A5A5A5A5A5A 1A5A5A5A5A1A5A5A5A5A
1 1234567890ABCDEF1234 12345678902BCDEF1234
1 77777777777777777777 37777777773777777777
1 BBBBBBBBBBBBBBBBBBBB 3BBBBBBBBB3BBBBBBBBB
1 EEEEEEEEEEEEEEEEEEEE 2EEEEEEEEE2EEEEEEEEE
1 00000000000000000001 00000000000000000001
1 40000000004000000000 00000000000000000000
1 FFFFFFFFFFFFFFFFFFFF 3FFFFFFFFF3FFFFFFFFF
1 00000000000000000000 00000000000000000000
# Short bypass tail before the random block
0 13579BDF02468ACE1357 13579BDF02468ACE1357
0 00000000000000000000 00000000000000000000

//--- verif/tb_aib_dbi_path.sv
//////////////////////////////////////////////////
// Self-checking testbench for the DBI loopback.
// Replays the tests file vectors, then random
// words, checking the pin word and data_out.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_aib_dbi_path;

  import aib_dbi_pkg::*;

  localparam int    CLK_HALF   = 50;      // 100 ns period
  localparam int    RST_CYCLES = 5;
  localparam int    TOGGLE_MAX = 9;       // Allowed toggles per group on the pins
  localparam int    HI_BASE    = 20;      // First lane of the high half at pin 40
  localparam int    DRAIN_MAX  = 8;       // Cycles allowed to empty the expected queue
  localparam int    MAX_LINES  = 1000;    // Guard on the file read loop
  localparam int    NUM_RAND   = 200;
  localparam string TESTS_FILE = "verif/aib_dbi_tests.txt";

  // Word in flight and the cycle it must show on data_out
  typedef struct packed {
    logic [31:0] due;
    logic        chk;     // Zero for idle words around a mode change
    word_t       word;
  } exp_entry_s;

  logic      clk;
  logic      rst_n;
  logic      dbi_en;
  word_t     data_in;
  pin_word_s pin_data;
  word_t     data_out;

  exp_entry_s exp_q[$];     // Expected words with the oldest first
  int         cyc;          // Words driven so far
  int         errors;
  int         checks;
  int         flagged;      // Inverted groups seen on the pins
  pin_word_s  prev_pin;     // Pin sample one cycle back
  logic       prev_valid;   // prev_pin was taken with DBI on

  aib_dbi_path uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .dbi_en   (dbi_en),
    .data_in  (data_in),
    .pin_data (pin_data),
    .data_out (data_out)
  );

  always #CLK_HALF clk = ~clk;

  // Differences between two lanes of one group where odd picks the odd pin
  function automatic int lane_toggles(word_t a, logic a_odd, word_t b, logic b_odd, int base);
    int n;
    n = 0;
    for (int k = 0; k < GRP_W; k++)
      if (a[2*(base+k) + int'(a_odd)] != b[2*(base+k) + int'(b_odd)])
        n++;
    return n;
  endfunction

  // User word after a DBI round trip with the flag pins read as zero
  function automatic word_t strip_flags(word_t w);
    word_t r;
    r = w;
    r[38] = 1'b0;   // Even-low flag
    r[39] = 1'b0;
    r[78] = 1'b0;
    r[79] = 1'b0;   // Odd-high flag
    return r;
  endfunction

  // Vector lines start with a hex digit and anything else is a comment
  function automatic bit is_data_line(string s);
    byte c;
    if (s.len() == 0)
      return 1'b0;
    c = s.getc(0);
    return (c >= "0" && c <= "9") || (c >= "a" && c <= "f") || (c >= "A" && c <= "F");
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  // Pin checks at mid cycle with raw as the word now in the encoder register
  task automatic check_pins(word_t raw, word_t cur_in);
    word_t      pw;
    word_t      prev_w;
    int         base;
    int         n_tog;
    logic [1:0] pair;
    pw     = word_t'(pin_data);
    prev_w = word_t'(prev_pin);
    if (!dbi_en)
    begin
      assert (pw === cur_in)   // Bypass is combinational
        else report_mismatch($sformatf("bypass pin_data %h, expected %h", pw, cur_in));
    end
    else
    begin
      for (int g = 0; g < 2; g++)
      begin
        base = (g == 0) ? 0 : HI_BASE;
        pair = (g == 0) ? pin_data.lo_flags : pin_data.hi_flags;   // [1] odd, [0] even
        // Odd pins go out right after the encoded even pins
        n_tog = lane_toggles(pw, 1'b1, pw, 1'b0, base);
        assert (n_tog <= TOGGLE_MAX)
          else report_mismatch($sformatf("group %0d toggles %0d pins", 2*g+1, n_tog));
        assert (pair[1] == (lane_toggles(raw, 1'b1, pw, 1'b0, base) > TOGGLE_MAX))
          else report_mismatch($sformatf("group %0d flag %b is wrong", 2*g+1, pair[1]));
        if (prev_valid)
        begin
          // Even pins follow the odd pins of the previous word
          n_tog = lane_toggles(pw, 1'b0, prev_w, 1'b1, base);
          assert (n_tog <= TOGGLE_MAX)
            else report_mismatch($sformatf("group %0d toggles %0d pins", 2*g, n_tog));
          assert (pair[0] == (lane_toggles(raw, 1'b0, prev_w, 1'b1, base) > TOGGLE_MAX))
            else report_mismatch($sformatf("group %0d flag %b is wrong", 2*g, pair[0]));
        end
        if (pair[0])
          flagged++;
        if (pair[1])
          flagged++;
      end
    end
    prev_pin   = pin_data;
    prev_valid = dbi_en;
  endtask

  // One clock that drives after the edge and samples pins and data_out at mid cycle
  task automatic drive_word(logic en, word_t din, word_t expected, logic push, logic chk);
    word_t      raw;
    exp_entry_s e;
    @(posedge clk);
    #1;
    raw     = data_in;
    dbi_en  = en;
    data_in = din;
    cyc++;
    if (push)
    begin
      e.due  = 32'(cyc + (en ? 2 : 1));   // Two stages with DBI and one in bypass
      e.chk  = chk;
      e.word = expected;
      exp_q.push_back(e);
    end
    @(negedge clk);
    check_pins(raw, din);
    while (exp_q.size() > 0 && exp_q[0].due <= 32'(cyc))
    begin
      e = exp_q.pop_front();
      if (e.chk)
      begin
        checks++;
        assert (data_out === e.word)
          else report_mismatch($sformatf("data_out %h, expected %h", data_out, e.word));
      end
    end
  endtask

  // Idle until every queued word has been seen
  task automatic drain(logic en);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_MAX)
    begin
      drive_word(en, '0, '0, 1'b0, 1'b0);
      waited++;
    end
    assert (exp_q.size() == 0)
      else
      begin
        errors++;
        $display("Timeout: %0d expected words never reached data_out", exp_q.size());
        exp_q.delete();
      end
  endtask

  // Enable only moves with the input idle on both sides
  task automatic switch_mode(logic old_en, logic new_en);
    drain(old_en);
    repeat (3) drive_word(old_en, '0, '0, 1'b0, 1'b0);
    repeat (3) drive_word(new_en, '0, '0, 1'b0, 1'b0);
  endtask

  initial
  begin
    int         fd;
    int         line_no;
    int         n_fields;
    int         n_file;
    string      line;
    logic [7:0] mode_v;
    word_t      din;
    word_t      exp_w;
    word_t      rule_w;
    logic       cur_en;

    void'($urandom(32'h1a0e));
    clk        = 1'b0;
    rst_n      = 1'b0;
    dbi_en     = 1'b1;      // DBI on so pin_data shows the encoder register
    data_in    = '0;
    cyc        = 0;
    errors     = 0;
    checks     = 0;
    flagged    = 0;
    prev_pin   = '0;
    prev_valid = 1'b0;
    cur_en     = 1'b1;
    line_no    = 0;
    n_file     = 0;

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Nothing sent yet
    @(negedge clk);
    assert (data_out === '0)
      else report_mismatch($sformatf("data_out %h after reset, expected zero", data_out));
    assert (pin_data === '0)
      else report_mismatch($sformatf("pin_data %h after reset, expected zero", pin_data));

    fd = $fopen(TESTS_FILE, "r");
    assert (fd != 0)
      else
      begin
        errors++;
        $display("Could not open the test vector file %s", TESTS_FILE);
      end
    if (fd != 0)
    begin
      while (!$feof(fd) && line_no < MAX_LINES)
      begin
        line = "";
        void'($fgets(line, fd));
        line_no++;
        if (is_data_line(line))
        begin
          n_fields = $sscanf(line, "%h %h %h", mode_v, din, exp_w);
          assert (n_fields == 3)
            else
            begin
              errors++;
              $display("Test file line %0d could not be parsed", line_no);
            end
          if (n_fields == 3)
          begin
            rule_w = mode_v[0] ? strip_flags(din) : din;
            assert (exp_w === rule_w)
              else
              begin
                errors++;
                $display("Test file line %0d expects %h but the DBI rule gives %h",
                         line_no, exp_w, rule_w);
              end
            if (mode_v[0] !== cur_en)
            begin
              switch_mode(cur_en, mode_v[0]);
              cur_en = mode_v[0];
            end
            drive_word(cur_en, din, exp_w, 1'b1, 1'b1);
            n_file++;
          end
        end
      end
      $fclose(fd);
    end
    drain(cur_en);

    // Random words with DBI on
    if (cur_en !== 1'b1)
    begin
      switch_mode(cur_en, 1'b1);
      cur_en = 1'b1;
    end
    for (int i = 0; i < NUM_RAND; i++)
    begin
      din = {16'($urandom), $urandom, $urandom};
      drive_word(1'b1, din, strip_flags(din), 1'b1, 1'b1);
    end
    drain(cur_en);

    // Every sent word reached data_out and the worst cases forced inversions
    assert (checks == n_file + NUM_RAND)
      else
      begin
        errors++;
        $display("Only %0d of %0d sent words were compared on data_out",
                 checks, n_file + NUM_RAND);
      end
    assert (flagged > 0)
      else
      begin
        errors++;
        $display("No DBI group was ever inverted on the pins");
      end

    $display("Done: %0d file words, %0d words checked, %0d inverted groups, %0d errors",
             n_file, checks, flagged, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
